// File: design/vga_pkg.sv
/*
  640x480 video timing, panel geometry and colours shared by the display blocks.
  Import into any module that works with beam positions or pixel colours.
*/
`default_nettype none

package vga_pkg;

  typedef logic [10:0] coord_t;  // screen coordinate, x or y

  typedef struct packed {
    logic [5:0] r;
    logic [5:0] g;
    logic [5:0] b;
  } rgb_t;

  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   active;  // beam inside the visible 640x480 area
  } beam_t;

  ////////////////////////////////////////
  // 640x480 @ 60 Hz, negative syncs
  localparam coord_t h_active     = 11'd640;
  localparam coord_t h_sync_start = 11'd656;
  localparam coord_t h_sync_end   = 11'd752;
  localparam coord_t h_total      = 11'd800;
  localparam coord_t v_active     = 11'd480;
  localparam coord_t v_sync_start = 11'd490;
  localparam coord_t v_sync_end   = 11'd492;
  localparam coord_t v_total      = 11'd525;

  ////////////////////////////////////////
  // panel block, switches on top and leds below
  localparam coord_t panel_y      = 11'd392;
  localparam coord_t led_y_offset = 11'd32;   // led row below switch row
  localparam coord_t sw_x0        = 11'd204;
  localparam coord_t sw_width     = 11'd232;  // 8 switches on a 32 px pitch, last one 8 wide
  localparam coord_t sw_height    = 11'd16;
  localparam coord_t led_x0       = 11'd200;
  localparam coord_t led_width    = 11'd240;  // 8 squares of 16 plus 7 gaps of 16
  localparam coord_t led_height   = 11'd6;

  localparam rgb_t colour_black   = '0;
  localparam rgb_t colour_outline = '{r: 6'h3F, g: 6'h3F, b: 6'h3F};
  localparam rgb_t colour_sw_on   = '{r: 6'h20, g: 6'h20, b: 6'h20};
  localparam rgb_t colour_sw_off  = '{r: 6'h00, g: 6'h00, b: 6'h20};
  localparam rgb_t colour_led_on  = '{r: 6'h3F, g: 6'h3F, b: 6'h1F};
  localparam rgb_t colour_led_off = '{r: 6'h10, g: 6'h00, b: 6'h00};

endpackage

`default_nettype wire

// File: design/ps2_pkg.sv
/*
  PS/2 keyboard frame states, prefix bytes, F-key scancodes and the key event.
*/
`default_nettype none

package ps2_pkg;

  // receive frame phases, one step per falling ps2 clock edge
  typedef enum logic [1:0] {
    start,
    data,
    parity,
    stop
  } ps2_state_t;

  localparam logic [7:0] code_extended = 8'hE0;  // next key is extended
  localparam logic [7:0] code_break    = 8'hF0;  // next key is a release

  localparam int deglitch_len   = 16;     // ps2 clock history length
  localparam int timeout_cycles = 65536;  // idle cycles before frame abort

  // indexed by switch number: [7] is F1 ... [0] is F8
  localparam logic [7:0][7:0] fkey_codes = {
    8'h05, 8'h06, 8'h04, 8'h0C, 8'h03, 8'h0B, 8'h83, 8'h0A
  };

  typedef struct packed {
    logic       valid;     // one cycle strobe
    logic       released;  // break code seen before this key
    logic       extended;  // E0 seen before this key
    logic [7:0] scancode;
  } key_event_t;

endpackage

`default_nettype wire

// File: design/video_timing.sv
/*
  Free running 640x480 beam counters with sync and active-area decode.
  Outputs are valid in the same cycle as the beam position they describe.
*/
`default_nettype none

module video_timing import vga_pkg::*; (
  input  logic  clk,
  input  logic  arst_n,
  output beam_t beam,
  output logic  hs,
  output logic  vs
);

  coord_t h_count;
  coord_t v_count;

  ////////////////////////////////////////
  // counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_count <= '0;
      v_count <= '0;
    end else begin
      if (h_count == h_total - 11'd1) begin
        h_count <= '0;                        // end of line
        if (v_count == v_total - 11'd1) begin
          v_count <= '0;                      // end of frame
        end else begin
          v_count <= v_count + 11'd1;
        end
      end else begin
        h_count <= h_count + 11'd1;
      end
    end
  end

  ////////////////////////////////////////
  // decode
  always_comb begin
    beam.x      = h_count;
    beam.y      = v_count;
    beam.active = (h_count < h_active) && (v_count < v_active);
    // both pulses active low
    hs = !((h_count >= h_sync_start) && (h_count < h_sync_end));
    vs = !((v_count >= v_sync_start) && (v_count < v_sync_end));
  end

endmodule

`default_nettype wire

// File: design/ps2_receiver.sv
/*
  PS/2 keyboard receiver. Syncs and deglitches the bus, collects 11-bit frames
  and folds E0/F0 prefixes into a single key event strobed for one cycle.
*/
`default_nettype none

module ps2_receiver import ps2_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output key_event_t key
);

  localparam int timeout_w = $clog2(timeout_cycles);
  // oldest four samples high, newest twelve low
  localparam logic [deglitch_len-1:0] edge_pattern =
    {{4{1'b1}}, {(deglitch_len-4){1'b0}}};

  logic [1:0]              clk_sync;
  logic [1:0]              data_sync;
  logic [deglitch_len-1:0] clk_hist;
  logic                    fall_edge;
  logic                    data_bit;
  logic [timeout_w-1:0]    idle_cnt;
  logic                    timeout_hit;

  ps2_state_t state;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic       ext_pend;  // E0 seen, waiting for the key byte
  logic       rel_pend;  // F0 seen, waiting for the key byte

  ////////////////////////////////////////
  // input path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clk_sync  <= 2'b11;  // bus idles high
      data_sync <= 2'b11;
      clk_hist  <= '1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_hist  <= {clk_hist[deglitch_len-2:0], clk_sync[1]};
    end
  end

  assign fall_edge = (clk_hist == edge_pattern);
  assign data_bit  = data_sync[1];

  // idle timer, restarts on every clock edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      idle_cnt <= '0;
    end else if (fall_edge) begin
      idle_cnt <= '0;
    end else begin
      idle_cnt <= idle_cnt + timeout_w'(1);  // wraps, harmless once back in start
    end
  end

  assign timeout_hit = (idle_cnt == timeout_w'(timeout_cycles - 1));

  ////////////////////////////////////////
  // frame FSM and prefix tracking
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= start;
      bit_cnt  <= '0;
      shift    <= '0;
      ext_pend <= 1'b0;
      rel_pend <= 1'b0;
      key      <= '0;
    end else begin
      key.valid <= 1'b0;  // strobe lasts one cycle
      if (fall_edge) begin
        case (state)
          start: begin
            if (!data_bit) begin  // start bit is 0
              state   <= data;
              bit_cnt <= '0;
            end
          end
          data: begin
            shift   <= {data_bit, shift[7:1]};  // lsb first
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= parity;
          end
          parity: begin
            // odd parity over data and parity bit
            state <= (^shift ^ data_bit) ? stop : start;
          end
          stop: begin
            state <= start;
            if (data_bit) begin
              if (shift == code_extended) begin
                ext_pend <= 1'b1;
              end else if (shift == code_break) begin
                rel_pend <= 1'b1;
              end else begin
                key.valid    <= 1'b1;
                key.released <= rel_pend;
                key.extended <= ext_pend;
                key.scancode <= shift;
                ext_pend     <= 1'b0;
                rel_pend     <= 1'b0;
              end
            end
          end
          default: state <= start;
        endcase
      end else if (timeout_hit) begin
        state <= start;  // stalled frame is dropped
      end
    end
  end

endmodule

`default_nettype wire

// File: design/switch_panel.sv
/*
  Eight on-screen toggle switches driven by F1..F8 make codes.
  Draws the switch row; colour is black outside the switch graphics.
*/
`default_nettype none

module switch_panel
  import vga_pkg::*;
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  key_event_t key,
  input  beam_t      beam,
  output logic [7:0] switch,
  output rgb_t       colour
);

  logic [7:0] toggle;   // one-hot switch to flip
  logic [7:0] rel_x;    // beam x from left edge of the row
  logic [3:0] rel_y;    // beam y from top of the row
  logic [2:0] sw_idx;   // switch under the beam
  logic       in_row;
  logic       sw_on;

  ////////////////////////////////////////
  // switch register
  always_comb begin
    toggle = '0;
    if (key.valid && !key.released && !key.extended) begin
      for (int k = 0; k < 8; k++) begin
        if (key.scancode == fkey_codes[k]) toggle[k] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      switch <= '0;
    end else begin
      switch <= switch ^ toggle;
    end
  end

  ////////////////////////////////////////
  // drawing
  assign rel_x  = 8'(beam.x - sw_x0);
  assign rel_y  = 4'(beam.y - panel_y);
  assign sw_idx = ~rel_x[7:5];     // leftmost graphic is switch 7
  assign sw_on  = switch[sw_idx];
  assign in_row = (beam.x >= sw_x0) && (beam.x < sw_x0 + sw_width) &&
                  (beam.y >= panel_y) && (beam.y < panel_y + sw_height);

  always_comb begin
    colour = colour_black;
    // each switch is 8 wide, the rest of its 32 px slot is gap
    if (in_row && rel_x[4:3] == 2'b00) begin
      if (rel_y == 4'd0 || rel_y == 4'(sw_height - 11'd1) ||
          rel_x[2:0] == 3'd0 || rel_x[2:0] == 3'd7) begin
        colour = colour_outline;   // frame
      end else if (!rel_y[3]) begin
        colour = sw_on ? colour_sw_on : colour_sw_off;   // upper half
      end else begin
        colour = sw_on ? colour_sw_off : colour_sw_on;   // lower half, swapped
      end
    end
  end

endmodule

`default_nettype wire

// File: design/led_panel.sv
/*
  Row of eight LED squares, lit or dark from the led inputs. Combinational.
*/
`default_nettype none

module led_panel import vga_pkg::*; (
  input  logic [7:0] led,
  input  beam_t      beam,
  output rgb_t       colour
);

  localparam coord_t led_y0 = panel_y + led_y_offset;

  logic [7:0] rel_x;   // offset p from the row's left edge
  logic [2:0] led_idx;
  logic       in_row;

  assign rel_x   = 8'(beam.x - led_x0);
  assign led_idx = ~rel_x[7:5];   // leftmost square is led 7
  assign in_row  = (beam.x >= led_x0) && (beam.x < led_x0 + led_width) &&
                   (beam.y >= led_y0) && (beam.y < led_y0 + led_height);

  always_comb begin
    colour = colour_black;
    // squares on the first 16 px of each 32 px slot
    if (in_row && !rel_x[4]) begin
      if (led[led_idx]) begin
        colour = colour_led_on;
      end else begin
        colour = colour_led_off;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/panel_display.sv
/*
  VGA status display top. Overlays switch and LED panels on the user picture
  and reports beam position and keyboard events to the user logic.
*/
`default_nettype none

module panel_display
  import vga_pkg::*;
  import ps2_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic [7:0] led,
  input  rgb_t       user_pixel,
  output logic       hs,
  output logic       vs,
  output rgb_t       pixel,
  output beam_t      beam,
  output logic [7:0] switch,
  output key_event_t key
);

  rgb_t sw_colour;
  rgb_t led_colour;
  rgb_t panel_colour;

  ////////////////////////////////////////
  // blocks
  video_timing u_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .beam   (beam),
    .hs     (hs),
    .vs     (vs)
  );

  ps2_receiver u_ps2 (
    .clk      (clk),
    .arst_n   (arst_n),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .key      (key)
  );

  switch_panel u_switches (
    .clk    (clk),
    .arst_n (arst_n),
    .key    (key),
    .beam   (beam),
    .switch (switch),
    .colour (sw_colour)
  );

  led_panel u_leds (
    .led    (led),
    .beam   (beam),
    .colour (led_colour)
  );

  ////////////////////////////////////////
  // pixel select, panels win over user picture
  assign panel_colour = rgb_t'(sw_colour | led_colour);

  always_comb begin
    if (!beam.active) begin
      pixel = colour_black;   // blanking
    end else if (panel_colour != colour_black) begin
      pixel = panel_colour;
    end else begin
      pixel = user_pixel;
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_panel_display.sv
/*
  Testbench for panel_display. Checks sync timing after reset, then replays
  keyboard frames, key expectations and pixel probes from tests/panel_tests.txt.
*/
`default_nettype none

module tb_panel_display import vga_pkg::*, ps2_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int frame_cycles = 800 * 525;
  localparam int half_period  = 40;    // system clocks per ps2 half period
  localparam int key_wait     = 2000;  // cycles allowed for a key strobe

  logic       clk;
  logic       arst_n;
  logic       ps2_clk;
  logic       ps2_data;
  logic [7:0] led;
  rgb_t       user_pixel;
  logic       hs;
  logic       vs;
  rgb_t       pixel;
  beam_t      beam;
  logic [7:0] switch;
  key_event_t key;

  key_event_t seen[$];    // strobes caught by the monitor
  logic [15:0] lfsr_state;
  logic [7:0]  sw_model;  // expected switch register
  int key_errs = 0;
  int pixel_errs = 0;
  int beam_errs = 0;
  int bit_errs = 0;
  int count_errs = 0;
  int other_errs = 0;

  panel_display uut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // one-cycle strobe, sampled mid-cycle
  always @(negedge clk) begin
    if (key.valid) seen.push_back(key);
  end

  ////////////////////////////////////////
  // compare tasks
  task automatic check_key(input string name, input key_event_t exp, input key_event_t act);
    if (exp !== act) begin
      key_errs++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_pixel(input string name, input rgb_t exp, input rgb_t act);
    if (exp !== act) begin
      pixel_errs++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_beam(input string name, input beam_t exp, input beam_t act);
    if (exp !== act) begin
      beam_errs++;
      $display("CHECK FAILED %s expected x=%0d y=%0d active=%b actual x=%0d y=%0d active=%b",
               name, exp.x, exp.y, exp.active, act.x, act.y, act.active);
    end
  endtask

  task automatic check_bit(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) begin
      bit_errs++;
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act) begin
      count_errs++;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // helpers
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic random_colour(output rgb_t c);
    for (int i = 0; i < 18; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // one step per bit
      c[i] = lfsr_state[0];
    end
  endtask

  // switch bit flipped by an F-key make code, F1 is the top bit
  function automatic logic [7:0] fkey_mask(input logic [7:0] code);
    case (code)
      8'h05:   fkey_mask = 8'h80;
      8'h06:   fkey_mask = 8'h40;
      8'h04:   fkey_mask = 8'h20;
      8'h0C:   fkey_mask = 8'h10;
      8'h03:   fkey_mask = 8'h08;
      8'h0B:   fkey_mask = 8'h04;
      8'h83:   fkey_mask = 8'h02;  // F7
      8'h0A:   fkey_mask = 8'h01;
      default: fkey_mask = 8'h00;
    endcase
  endfunction

  // cycles until hs or vs reaches level, bounded by limit
  task automatic cycles_until(input logic use_vs, input logic level, input int limit,
                              output int n);
    n = 0;
    while ((use_vs ? vs : hs) !== level && n <= limit) begin
      @(negedge clk);
      n++;
    end
    if ((use_vs ? vs : hs) !== level) begin
      other_errs++;
      $display("timeout: %s never went %b", use_vs ? "vs" : "hs", level);
    end
  endtask

  task automatic send_byte(input logic [7:0] b, input logic good);
    logic [10:0] frame;
    frame = {1'b1, (~^b) ^ ~good, b, 1'b0};  // stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];  // lsb first, changed while ps2_clk is high
      repeat (half_period) @(negedge clk);
      ps2_clk = 1'b0;
      repeat (half_period) @(negedge clk);
      ps2_clk = 1'b1;
    end
    repeat (half_period) @(negedge clk);
  endtask

  task automatic wait_event();
    int n;
    n = 0;
    while (seen.size() == 0 && n < key_wait) begin
      @(negedge clk);
      n++;
    end
  endtask

  task automatic expect_key(input string name, input key_event_t exp);
    wait_event();
    if (seen.size() == 0) begin
      other_errs++;
      $display("timeout: no key event arrived for %s", name);
    end else begin
      check_key(name, exp, seen.pop_front());
      @(negedge clk);  // register follows the strobe by one cycle
      if (!exp.released && !exp.extended) sw_model ^= fkey_mask(exp.scancode);
      check_bit({name, " switches"}, sw_model, switch);
    end
  endtask

  task automatic expect_none(input string name);
    wait_event();
    if (seen.size() != 0) begin
      other_errs++;
      $display("%s gave an unexpected key event %h", name, seen.pop_front());
    end
  endtask

  task automatic probe(input coord_t x, input coord_t y, input logic [7:0] leds,
                       input string src);
    rgb_t  exp;
    int    n;
    string name;
    name = $sformatf("pixel %0d,%0d", x, y);
    led = leds;
    random_colour(user_pixel);
    n = 0;
    while (!(beam.x == x && beam.y == y) && n <= frame_cycles) begin
      @(negedge clk);
      n++;
    end
    case (src)
      "led_on":     exp = colour_led_on;
      "led_off":    exp = colour_led_off;
      "sw_outline": exp = colour_outline;
      "sw_on":      exp = colour_sw_on;
      "sw_off":     exp = colour_sw_off;
      "user":       exp = user_pixel;
      default:      exp = '0;  // blanking
    endcase
    if (!(beam.x == x && beam.y == y)) begin
      other_errs++;
      $display("timeout: beam never reached %s", name);
    end else begin
      check_pixel(name, exp, pixel);
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  initial begin
    int          fd;
    int          n;
    int          tests;
    string       line;
    string       src;
    logic [7:0]  b;
    logic        flag;
    logic        rel;
    logic        ext;
    coord_t      px;
    coord_t      py;
    key_event_t  exp_key;
    beam_t       exp_beam;
    arst_n = 1'b0;
    ps2_clk = 1'b1;   // bus idle
    ps2_data = 1'b1;
    led = '0;
    user_pixel = '0;
    lfsr_state = 16'd53173;
    sw_model = '0;
    tests = 0;
    repeat (8) @(negedge clk);
    arst_n = 1'b1;

    // beam at 0,0 here
    exp_beam = '{x: 11'd0, y: 11'd0, active: 1'b1};
    check_beam("beam after reset", exp_beam, beam);
    check_bit("hs after reset", 8'h01, 8'(hs));
    check_bit("vs after reset", 8'h01, 8'(vs));
    cycles_until(1'b0, 1'b0, 1000, n);
    check_count("hs fall position", 656, n);
    exp_beam = '{x: 11'd656, y: 11'd0, active: 1'b0};
    check_beam("beam at hs fall", exp_beam, beam);
    cycles_until(1'b0, 1'b1, 1000, n);
    check_count("hs low cycles", 96, n);
    exp_beam = '{x: 11'd752, y: 11'd0, active: 1'b0};
    check_beam("beam at hs rise", exp_beam, beam);
    cycles_until(1'b0, 1'b0, 1000, n);
    check_count("hs period", 800, 96 + n);
    cycles_until(1'b1, 1'b0, frame_cycles, n);
    exp_beam = '{x: 11'd0, y: 11'd490, active: 1'b0};
    check_beam("beam at vs fall", exp_beam, beam);
    cycles_until(1'b1, 1'b1, frame_cycles, n);
    check_count("vs low cycles", 2 * 800, n);
    exp_beam = '{x: 11'd0, y: 11'd492, active: 1'b0};
    check_beam("beam at vs rise", exp_beam, beam);
    cycles_until(1'b1, 1'b0, frame_cycles, n);
    check_count("vs period", frame_cycles, 2 * 800 + n);

    fd = $fopen("tests/panel_tests.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open tests/panel_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") continue;
        tests++;
        case (line.getc(0))
          "B": begin
            void'($sscanf(line, "B %h %d", b, flag));
            send_byte(b, flag);
          end
          "K": begin
            void'($sscanf(line, "K %d %d %h", rel, ext, b));
            exp_key = '{valid: 1'b1, released: rel, extended: ext, scancode: b};
            expect_key($sformatf("key line %0d", tests), exp_key);
          end
          "N": expect_none($sformatf("no-key line %0d", tests));
          "P": begin
            void'($sscanf(line, "P %d %d %h %s", px, py, b, src));
            probe(px, py, b, src);
          end
          default: begin
            other_errs++;
            $display("unknown line in data file: %s", line);
          end
        endcase
      end
      $fclose(fd);
    end

    $display("errors: key=%0d pixel=%0d beam=%0d bit=%0d count=%0d other=%0d",
             key_errs, pixel_errs, beam_errs, bit_errs, count_errs, other_errs);
    if (key_errs + pixel_errs + beam_errs + bit_errs + count_errs + other_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/panel_tests.txt
# B <byte hex> <parity ok 1/0> | K <released> <extended> <scancode hex> | N = no key event
# P <x> <y> <led hex> <source: led_on led_off sw_outline sw_on sw_off user black>
B 1C 1
K 0 0 1C
B E0 1
N
B 75 1
K 0 1 75
B 05 0
N
B 05 1
K 0 0 05
B 83 1
K 0 0 83
B F0 1
B 05 1
K 1 0 05
B E0 1
B 0A 1
K 0 1 0A
B 0A 1
K 0 0 0A
P 700 100 FF black
P 320 240 00 user
P 204 392 00 sw_outline
P 206 395 00 sw_on
P 215 395 00 user
P 238 395 00 sw_off
P 206 403 00 sw_off
P 205 426 80 led_on
P 220 426 FF user
P 237 426 80 led_off
P 430 427 01 led_on
P 100 500 FF black

// File: sim.f
design/vga_pkg.sv
design/ps2_pkg.sv
design/video_timing.sv
design/ps2_receiver.sv
design/switch_panel.sv
design/led_panel.sv
design/panel_display.sv
tests/tb_panel_display.sv

// File: Makefile
# Verilator build and run of the panel_display testbench
TOP := tb_panel_display

all: run

obj_dir/V$(TOP): sim.f design/*.sv tests/*.sv
	verilator --binary --timing -f sim.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

lint:
	verilator --lint-only -Wall --top-module panel_display \
	  design/vga_pkg.sv design/ps2_pkg.sv design/video_timing.sv \
	  design/ps2_receiver.sv design/switch_panel.sv design/led_panel.sv \
	  design/panel_display.sv

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
